/* src/crg_pkg.sv */
package crg_pkg;

    // field widths of one pll setting
    localparam int unsigned refdiv_w  = 6;
    localparam int unsigned fbdiv_w   = 12;
    localparam int unsigned postdiv_w = 3;

    // config pin widths
    localparam int unsigned core_mode_w = 4;
    localparam int unsigned dev_mode_w  = 2;

    // core mode pins, codes 9..15 fall back to bypass
    typedef enum logic [core_mode_w-1:0] {
        core_bypass = 4'd0,
        core_x5     = 4'd1,
        core_x6     = 4'd2,
        core_x7     = 4'd3,
        core_x8     = 4'd4,
        core_x9     = 4'd5,
        core_x10    = 4'd6,
        core_x11    = 4'd7,
        core_x12    = 4'd8
    } core_mode_e;

    // device mode pins
    typedef enum logic [dev_mode_w-1:0] {
        dev_bypass     = 2'd0,
        dev_x1p5       = 2'd1,
        dev_x2         = 2'd2,
        dev_bypass_alt = 2'd3
    } dev_mode_e;

    // setting driven while the pll is bypassed
    localparam logic [refdiv_w-1:0]  bypass_refdiv  = 6'd2;
    localparam logic [fbdiv_w-1:0]   bypass_fbdiv   = 12'd20;
    localparam logic [postdiv_w-1:0] bypass_postdiv = 3'd1;

    // core pll, fixed fields of the multiply modes
    localparam logic [refdiv_w-1:0]  core_refdiv    = 6'd2;
    localparam logic [postdiv_w-1:0] core_postdiv1  = 3'd2;
    localparam logic [postdiv_w-1:0] core_postdiv2  = 3'd1;
    localparam logic [fbdiv_w-1:0]   core_fbdiv_min = 12'd20;
    localparam logic [fbdiv_w-1:0]   core_fbdiv_max = 12'd48;

    // device pll, 1.5x rate
    localparam logic [refdiv_w-1:0]  dev_x1p5_refdiv   = 6'd4;
    localparam logic [fbdiv_w-1:0]   dev_x1p5_fbdiv    = 12'd30;
    localparam logic [postdiv_w-1:0] dev_x1p5_postdiv1 = 3'd5;
    localparam logic [postdiv_w-1:0] dev_x1p5_postdiv2 = 3'd1;

    // device pll, 2x rate
    localparam logic [refdiv_w-1:0]  dev_x2_refdiv   = 6'd2;
    localparam logic [fbdiv_w-1:0]   dev_x2_fbdiv    = 12'd24;
    localparam logic [postdiv_w-1:0] dev_x2_postdiv1 = 3'd3;
    localparam logic [postdiv_w-1:0] dev_x2_postdiv2 = 3'd2;

endpackage

/* src/pll_setting_if.sv */
`timescale 1ns/10ps

// one decoded pll setting, a level with no handshake
interface pll_setting_if;

    logic                            bypass;
    logic [crg_pkg::refdiv_w-1:0]    refdiv;
    logic [crg_pkg::fbdiv_w-1:0]     fbdiv;
    logic [crg_pkg::postdiv_w-1:0]   postdiv1;
    logic [crg_pkg::postdiv_w-1:0]   postdiv2;

    // decoder side
    modport src (
        output bypass,
        output refdiv,
        output fbdiv,
        output postdiv1,
        output postdiv2
    );

    modport dst (
        input bypass,
        input refdiv,
        input fbdiv,
        input postdiv1,
        input postdiv2
    );

endinterface

/* src/reset_sequencer.sv */
`timescale 1ns/10ps

module reset_sequencer #(
    parameter int unsigned RST_CNT_W   = 20,
    parameter int unsigned RST_CNT_END = 131071
) (
    input  logic sys_clk,
    input  logic rst_sync_n,
    output logic rst_core_o
);

    localparam logic [RST_CNT_W-1:0] CNT_END = RST_CNT_W'(RST_CNT_END);

    logic [2:0]           sync_q;
    logic                 rst_int_n;
    logic [RST_CNT_W-1:0] rst_cnt_q;

    // three-stage release synchronizer, assertion stays asynchronous
    always_ff @(posedge sys_clk or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            sync_q <= 3'b000;
        end else begin
            sync_q <= {sync_q[1:0], 1'b1};
        end
    end

    assign rst_int_n = sync_q[2];

    // release counter, saturates at the end value
    always_ff @(posedge sys_clk or negedge rst_int_n) begin
        if (!rst_int_n) begin
            rst_cnt_q <= '0;
        end else if (rst_cnt_q < CNT_END) begin
            rst_cnt_q <= rst_cnt_q + 1'b1;
        end
    end

    // core domain leaves reset once the count is done
    assign rst_core_o = (rst_cnt_q == CNT_END);

    // count never runs past the release point
    cnt_in_range_a: assert property (
        @(posedge sys_clk) disable iff (!rst_sync_n)
        rst_cnt_q <= CNT_END
    ) else $error("reset counter passed its end value");

    // no glitch back into reset while the board reset stays released
    core_rst_hold_a: assert property (
        @(posedge sys_clk) disable iff (!rst_sync_n)
        rst_core_o |=> rst_core_o
    ) else $error("core reset re-asserted without board reset");

endmodule

/* src/core_pll_decoder.sv */
`timescale 1ns/10ps

module core_pll_decoder (
    input  logic [crg_pkg::core_mode_w-1:0] core_mode_i,
    pll_setting_if.src                      setting
);

    crg_pkg::core_mode_e             mode;
    logic                            bypass;
    logic [crg_pkg::refdiv_w-1:0]    refdiv;
    logic [crg_pkg::fbdiv_w-1:0]     fbdiv;
    logic [crg_pkg::postdiv_w-1:0]   postdiv1;
    logic [crg_pkg::postdiv_w-1:0]   postdiv2;

    assign mode = crg_pkg::core_mode_e'(core_mode_i);

    always_comb begin
        // multiply modes share everything but the feedback divider
        bypass   = 1'b0;
        refdiv   = crg_pkg::core_refdiv;
        fbdiv    = crg_pkg::bypass_fbdiv;
        postdiv1 = crg_pkg::core_postdiv1;
        postdiv2 = crg_pkg::core_postdiv2;
        case (mode)
            crg_pkg::core_x5:  fbdiv = 12'd20;
            crg_pkg::core_x6:  fbdiv = 12'd24;
            crg_pkg::core_x7:  fbdiv = 12'd28;
            crg_pkg::core_x8:  fbdiv = 12'd32;
            crg_pkg::core_x9:  fbdiv = 12'd36;
            crg_pkg::core_x10: fbdiv = 12'd40;
            crg_pkg::core_x11: fbdiv = 12'd44;
            crg_pkg::core_x12: fbdiv = 12'd48;
            // core_bypass and the unused codes 9..15
            default: begin
                bypass   = 1'b1;
                refdiv   = crg_pkg::bypass_refdiv;
                fbdiv    = crg_pkg::bypass_fbdiv;
                postdiv1 = crg_pkg::bypass_postdiv;
                postdiv2 = crg_pkg::bypass_postdiv;
            end
        endcase
    end

    assign setting.bypass   = bypass;
    assign setting.refdiv   = refdiv;
    assign setting.fbdiv    = fbdiv;
    assign setting.postdiv1 = postdiv1;
    assign setting.postdiv2 = postdiv2;

    // vco must stay inside the lockable range when the pll is in use
    always_comb begin
        if (!bypass) begin
            fbdiv_range_a: assert final (
                fbdiv >= crg_pkg::core_fbdiv_min &&
                fbdiv <= crg_pkg::core_fbdiv_max &&
                refdiv != '0
            ) else $error("core pll setting out of range for mode %0d", core_mode_i);
        end
    end

endmodule

/* src/dev_pll_decoder.sv */
`timescale 1ns/10ps

module dev_pll_decoder (
    input  logic [crg_pkg::dev_mode_w-1:0] dev_mode_i,
    pll_setting_if.src                     setting
);

    crg_pkg::dev_mode_e              mode;
    logic                            bypass;
    logic [crg_pkg::refdiv_w-1:0]    refdiv;
    logic [crg_pkg::fbdiv_w-1:0]     fbdiv;
    logic [crg_pkg::postdiv_w-1:0]   postdiv1;
    logic [crg_pkg::postdiv_w-1:0]   postdiv2;

    assign mode = crg_pkg::dev_mode_e'(dev_mode_i);

    always_comb begin
        case (mode)
            crg_pkg::dev_x1p5: begin
                bypass   = 1'b0;
                refdiv   = crg_pkg::dev_x1p5_refdiv;
                fbdiv    = crg_pkg::dev_x1p5_fbdiv;
                postdiv1 = crg_pkg::dev_x1p5_postdiv1;
                postdiv2 = crg_pkg::dev_x1p5_postdiv2;
            end
            crg_pkg::dev_x2: begin
                bypass   = 1'b0;
                refdiv   = crg_pkg::dev_x2_refdiv;
                fbdiv    = crg_pkg::dev_x2_fbdiv;
                postdiv1 = crg_pkg::dev_x2_postdiv1;
                postdiv2 = crg_pkg::dev_x2_postdiv2;
            end
            // dev_bypass and dev_bypass_alt
            default: begin
                bypass   = 1'b1;
                refdiv   = crg_pkg::bypass_refdiv;
                fbdiv    = crg_pkg::bypass_fbdiv;
                postdiv1 = crg_pkg::bypass_postdiv;
                postdiv2 = crg_pkg::bypass_postdiv;
            end
        endcase
    end

    assign setting.bypass   = bypass;
    assign setting.refdiv   = refdiv;
    assign setting.fbdiv    = fbdiv;
    assign setting.postdiv1 = postdiv1;
    assign setting.postdiv2 = postdiv2;

    // post divider chain expects the larger ratio first
    always_comb begin
        if (!bypass) begin
            postdiv_order_a: assert final (postdiv1 >= postdiv2)
                else $error("device postdiv1 below postdiv2 for mode %0d", dev_mode_i);
        end
    end

endmodule

/* src/crg_top.sv */
`timescale 1ns/10ps

module crg_top #(
    parameter int unsigned RST_CNT_W   = 20,
    parameter int unsigned RST_CNT_END = 131071
) (
    input  logic                             sys_clk,
    input  logic                             rst_sync_n,
    input  logic [crg_pkg::core_mode_w-1:0]  core_mode_i,
    input  logic [crg_pkg::dev_mode_w-1:0]   dev_mode_i,

    output logic                             rst_core_o,

    // core pll setting
    output logic                             core_bypass_o,
    output logic [crg_pkg::refdiv_w-1:0]     core_refdiv_o,
    output logic [crg_pkg::fbdiv_w-1:0]      core_fbdiv_o,
    output logic [crg_pkg::postdiv_w-1:0]    core_postdiv1_o,
    output logic [crg_pkg::postdiv_w-1:0]    core_postdiv2_o,

    // device pll setting
    output logic                             dev_bypass_o,
    output logic [crg_pkg::refdiv_w-1:0]     dev_refdiv_o,
    output logic [crg_pkg::fbdiv_w-1:0]      dev_fbdiv_o,
    output logic [crg_pkg::postdiv_w-1:0]    dev_postdiv1_o,
    output logic [crg_pkg::postdiv_w-1:0]    dev_postdiv2_o
);

    pll_setting_if core_setting();
    pll_setting_if dev_setting();

    reset_sequencer #(
        .RST_CNT_W   (RST_CNT_W),
        .RST_CNT_END (RST_CNT_END)
    ) u_reset_sequencer (
        .sys_clk     (sys_clk),
        .rst_sync_n  (rst_sync_n),
        .rst_core_o  (rst_core_o)
    );

    core_pll_decoder u_core_pll_decoder (
        .core_mode_i (core_mode_i),
        .setting     (core_setting.src)
    );

    dev_pll_decoder u_dev_pll_decoder (
        .dev_mode_i  (dev_mode_i),
        .setting     (dev_setting.src)
    );

    // break the settings out towards the pll macros
    assign core_bypass_o   = core_setting.bypass;
    assign core_refdiv_o   = core_setting.refdiv;
    assign core_fbdiv_o    = core_setting.fbdiv;
    assign core_postdiv1_o = core_setting.postdiv1;
    assign core_postdiv2_o = core_setting.postdiv2;

    assign dev_bypass_o    = dev_setting.bypass;
    assign dev_refdiv_o    = dev_setting.refdiv;
    assign dev_fbdiv_o     = dev_setting.fbdiv;
    assign dev_postdiv1_o  = dev_setting.postdiv1;
    assign dev_postdiv2_o  = dev_setting.postdiv2;

endmodule

/* verification/crg_tb.sv */
`timescale 1ns/10ps

module crg_tb;

    localparam int unsigned RST_CNT_W   = 20;
    localparam int unsigned RST_CNT_END = 16;
    localparam int          MAX_VEC     = 64;
    localparam int          MAX_RST     = 16;

    logic                             sys_clk;
    logic                             rst_sync_n;
    logic [crg_pkg::core_mode_w-1:0]  core_mode_i;
    logic [crg_pkg::dev_mode_w-1:0]   dev_mode_i;
    logic                             rst_core_o;
    logic                             core_bypass_o;
    logic [crg_pkg::refdiv_w-1:0]     core_refdiv_o;
    logic [crg_pkg::fbdiv_w-1:0]      core_fbdiv_o;
    logic [crg_pkg::postdiv_w-1:0]    core_postdiv1_o;
    logic [crg_pkg::postdiv_w-1:0]    core_postdiv2_o;
    logic                             dev_bypass_o;
    logic [crg_pkg::refdiv_w-1:0]     dev_refdiv_o;
    logic [crg_pkg::fbdiv_w-1:0]      dev_fbdiv_o;
    logic [crg_pkg::postdiv_w-1:0]    dev_postdiv1_o;
    logic [crg_pkg::postdiv_w-1:0]    dev_postdiv2_o;

    // vector columns are core and dev mode, then five core and five device fields
    int vec_tab [0:MAX_VEC-1][0:11];
    int rst_tab [0:MAX_RST-1];
    int vec_cnt      = 0;
    int rst_case_cnt = 0;
    int pass_cnt     = 0;
    int fail_cnt     = 0;
    bit load_done    = 1'b0;

    crg_top #(
        .RST_CNT_W   (RST_CNT_W),
        .RST_CNT_END (RST_CNT_END)
    ) dut (
        .sys_clk         (sys_clk),
        .rst_sync_n      (rst_sync_n),
        .core_mode_i     (core_mode_i),
        .dev_mode_i      (dev_mode_i),
        .rst_core_o      (rst_core_o),
        .core_bypass_o   (core_bypass_o),
        .core_refdiv_o   (core_refdiv_o),
        .core_fbdiv_o    (core_fbdiv_o),
        .core_postdiv1_o (core_postdiv1_o),
        .core_postdiv2_o (core_postdiv2_o),
        .dev_bypass_o    (dev_bypass_o),
        .dev_refdiv_o    (dev_refdiv_o),
        .dev_fbdiv_o     (dev_fbdiv_o),
        .dev_postdiv1_o  (dev_postdiv1_o),
        .dev_postdiv2_o  (dev_postdiv2_o)
    );

    always #2 sys_clk = ~sys_clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, inout int errs);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            errs++;
        end
    endtask

    task automatic finish_test(input string name, input int errs);
        if (errs == 0) begin
            $display("test %s: passed", name);
            pass_cnt++;
        end else begin
            $display("test %s: failed with %0d errors", name, errs);
            fail_cnt++;
        end
    endtask

    // drive one mode pair and compare the ten decoded fields
    task automatic apply_vector(input int idx, inout int errs);
        core_mode_i = vec_tab[idx][0];
        dev_mode_i  = vec_tab[idx][1];
        #1;
        check_value("core_bypass_o", vec_tab[idx][2], core_bypass_o, errs);
        check_value("core_refdiv_o", vec_tab[idx][3], core_refdiv_o, errs);
        check_value("core_fbdiv_o", vec_tab[idx][4], core_fbdiv_o, errs);
        check_value("core_postdiv1_o", vec_tab[idx][5], core_postdiv1_o, errs);
        check_value("core_postdiv2_o", vec_tab[idx][6], core_postdiv2_o, errs);
        check_value("dev_bypass_o", vec_tab[idx][7], dev_bypass_o, errs);
        check_value("dev_refdiv_o", vec_tab[idx][8], dev_refdiv_o, errs);
        check_value("dev_fbdiv_o", vec_tab[idx][9], dev_fbdiv_o, errs);
        check_value("dev_postdiv1_o", vec_tab[idx][10], dev_postdiv1_o, errs);
        check_value("dev_postdiv2_o", vec_tab[idx][11], dev_postdiv2_o, errs);
    endtask

    // called on a falling edge to release the board reset and count edges
    task automatic measure_release(inout int errs);
        int edges;
        int expect_edges;
        edges        = 0;
        expect_edges = 3 + RST_CNT_END;
        rst_sync_n   = 1'b1;
        #1;
        check_value("rst_core_o", 0, rst_core_o, errs);
        while (rst_core_o !== 1'b1 && edges < expect_edges + 8) begin
            @(negedge sys_clk);
            edges++;
            // modes move around while the count runs
            apply_vector($urandom_range(vec_cnt - 1, 0), errs);
        end
        if (rst_core_o !== 1'b1) begin
            $display("rst_core_o was still low %0d edges after reset release", edges);
            errs++;
        end else begin
            check_value("rst_core_o release edges", expect_edges, edges, errs);
        end
    endtask

    task automatic run_reset_case(input int idx);
        int n;
        int errs;
        errs = 0;
        n    = rst_tab[idx];
        @(negedge sys_clk);
        rst_sync_n = 1'b0;
        #1;
        check_value("rst_core_o", 0, rst_core_o, errs);
        repeat (2) @(negedge sys_clk);
        rst_sync_n = 1'b1;
        repeat (n) @(negedge sys_clk);
        check_value("rst_core_o", (n >= 3 + RST_CNT_END), rst_core_o, errs);
        // board reset drops partway through the count
        rst_sync_n = 1'b0;
        #1;
        check_value("rst_core_o", 0, rst_core_o, errs);
        repeat (2) @(negedge sys_clk);
        measure_release(errs);
        finish_test($sformatf("reset case %0d after %0d cycles", idx, n), errs);
    endtask

    initial begin : watchdog
        int limit;
        wait (load_done);
        limit = vec_cnt * 2 + rst_case_cnt * (RST_CNT_END + 10) + 200;
        repeat (limit) @(posedge sys_clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        int fd;
        int nf;
        int kind;
        int errs;
        int fld [0:11];
        logic [8*256-1:0] line_buf;
        sys_clk     = 1'b0;
        rst_sync_n  = 1'b0;
        core_mode_i = '0;
        dev_mode_i  = '0;
        void'($urandom(32'ha00f));
        fd = $fopen("verification/crg_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/crg_testdata.txt");
            $display("** FAIL **");
            $finish;
        end else begin
            while ($fgets(line_buf, fd) != 0) begin
                nf = $sscanf(line_buf, "%d %d %d %d %d %d %d %d %d %d %d %d %d", kind,
                             fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                             fld[6], fld[7], fld[8], fld[9], fld[10], fld[11]);
                if (nf == 13 && kind == 0 && vec_cnt < MAX_VEC) begin
                    for (int i = 0; i < 12; i++) begin
                        vec_tab[vec_cnt][i] = fld[i];
                    end
                    vec_cnt++;
                end else if (nf == 2 && kind == 1 && rst_case_cnt < MAX_RST) begin
                    rst_tab[rst_case_cnt] = fld[0];
                    rst_case_cnt++;
                end else if (nf > 0) begin
                    $display("data file line could not be parsed");
                    fail_cnt++;
                end
            end
            $fclose(fd);
            load_done = 1'b1;

            repeat (2) @(negedge sys_clk);
            errs = 0;
            measure_release(errs);
            finish_test("initial reset release", errs);

            for (int i = 0; i < vec_cnt; i++) begin
                @(negedge sys_clk);
                errs = 0;
                apply_vector(i, errs);
                repeat ($urandom_range(1, 0)) @(negedge sys_clk);
                finish_test($sformatf("vector %0d", i), errs);
            end

            for (int i = 0; i < rst_case_cnt; i++) begin
                run_reset_case(i);
            end

            $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0 && vec_cnt > 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

endmodule

/* verification/crg_testdata.txt */
# kind 0: core_mode dev_mode core_bypass core_refdiv core_fbdiv core_postdiv1 core_postdiv2
#         dev_bypass dev_refdiv dev_fbdiv dev_postdiv1 dev_postdiv2
# kind 1: cycles after reset release before the board reset is lowered again

# core multiply modes, device modes cycling
0 0 0 1 2 20 1 1 1 2 20 1 1
0 1 1 0 2 20 2 1 0 4 30 5 1
0 2 2 0 2 24 2 1 0 2 24 3 2
0 3 3 0 2 28 2 1 1 2 20 1 1
0 4 0 0 2 32 2 1 1 2 20 1 1
0 5 1 0 2 36 2 1 0 4 30 5 1
0 6 2 0 2 40 2 1 0 2 24 3 2
0 7 3 0 2 44 2 1 1 2 20 1 1
0 8 0 0 2 48 2 1 1 2 20 1 1

# unused core codes fall back to bypass
0 9 1 1 2 20 1 1 0 4 30 5 1
0 10 2 1 2 20 1 1 0 2 24 3 2
0 11 3 1 2 20 1 1 1 2 20 1 1
0 12 0 1 2 20 1 1 1 2 20 1 1
0 13 1 1 2 20 1 1 0 4 30 5 1
0 14 2 1 2 20 1 1 0 2 24 3 2
0 15 3 1 2 20 1 1 1 2 20 1 1

# reset cases, release takes 19 edges with the count end at 16
1 4
1 11
1 18
1 19
1 24

/* list.f */
src/crg_pkg.sv
src/pll_setting_if.sv
src/reset_sequencer.sv
src/core_pll_decoder.sv
src/dev_pll_decoder.sv
src/crg_top.sv
verification/crg_tb.sv

/* Bender.yml */
package:
  name: crg

sources:
  - src/crg_pkg.sv
  - src/pll_setting_if.sv
  - src/reset_sequencer.sv
  - src/core_pll_decoder.sv
  - src/dev_pll_decoder.sv
  - src/crg_top.sv
  - target: test
    files:
      - verification/crg_tb.sv
